// ==== design/i8008_pkg.sv ====
package i8008_pkg;

  localparam int ADDR_W = 14;
  localparam int DATA_W = 8;

  // T-states of one machine cycle
  typedef enum logic [2:0] {
    T1, T2, WAIT, T3, T4, T5, STOPPED
  } state_t;

  typedef enum logic [1:0] {
    CYCLE1, CYCLE2, CYCLE3
  } cycle_t;

  // Scratchpad index, code 7 is the memory operand M
  typedef enum logic [2:0] {
    REG_A, REG_B, REG_C, REG_D, REG_E, REG_H, REG_L, REG_M
  } reg_sel_t;

  // Same order as instruction bits 5:3
  typedef enum logic [2:0] {
    ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBB, ALU_AND, ALU_XOR, ALU_OR, ALU_CMP
  } alu_op_t;

  typedef enum logic [2:0] {
    ROT_INC, ROT_DEC, ROT_RLC, ROT_RRC, ROT_RAL, ROT_RAR
  } rot_op_t;

  typedef struct packed {
    logic carry;
    logic zero;
    logic sign;
    logic parity;  // Set on even parity
  } flags_t;

  typedef struct packed {
    alu_op_t op;
    rot_op_t rot;
    logic    arith;    // Use rot instead of op
    logic    flag_en;
    logic    re;       // Result onto internal bus
  } alu_ctrl_t;

  typedef struct packed {
    reg_sel_t sel;
    logic     we;
    logic     re;
  } rf_ctrl_t;

  typedef enum logic {
    MEM_READ, PORT_WRITE
  } bus_kind_t;

  typedef struct packed {
    bus_kind_t         kind;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } bus_cmd_t;

  typedef struct packed {
    rf_ctrl_t  rf;
    alu_ctrl_t alu;
    logic      a_we;
    logic      a_re;
    logic      b_we;
    logic      b_re;
    logic      rd_re;     // Captured bus byte onto internal bus
    logic      ir_ld;
    logic      pc_inc;
    logic      pc_ld_lo;
    logic      pc_ld_hi;
    logic      bus_start;
    bus_kind_t bus_kind;
  } ctrl_t;

  // Opcode patterns, ? bits are don't care in casez
  parameter logic [7:0] HLT   = 8'b1111_1111;
  parameter logic [7:0] HLT0  = 8'b0000_000?;
  parameter logic [7:0] LRR   = 8'b11??_????;
  parameter logic [7:0] LRI   = 8'b00??_?110;
  parameter logic [7:0] ALU_R = 8'b10??_????;
  parameter logic [7:0] ALU_I = 8'b00??_?100;
  parameter logic [7:0] INR   = 8'b00??_?000;
  parameter logic [7:0] DCR   = 8'b00??_?001;
  parameter logic [7:0] ROT   = 8'b000?_?010;
  parameter logic [7:0] JMP   = 8'b01??_?100;
  parameter logic [7:0] JCOND = 8'b01??_?000;
  parameter logic [7:0] OUT   = 8'b01??_???1;  // Bits 5:4 of 00 is INP

endpackage

// ==== design/i8008_alu.sv ====
`timescale 1ns/1ps

module i8008_alu import i8008_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  input  alu_ctrl_t         alu_ctrl,
  output logic [DATA_W-1:0] result,
  output flags_t            flags
);

  logic [DATA_W:0]   sum;       // Carry or borrow in the top bit
  logic [DATA_W-1:0] flag_src;  // Value seen by zero, sign and parity
  logic              zsp_upd;
  flags_t            flags_next;

  always_comb begin
    sum        = '0;
    result     = a;
    flag_src   = a;
    zsp_upd    = 1'b0;
    flags_next = flags;
    if (alu_ctrl.arith) begin
      unique case (alu_ctrl.rot)
        ROT_INC: begin
          result   = a + 1'b1;
          flag_src = result;
          zsp_upd  = 1'b1;  // Carry kept
        end
        ROT_DEC: begin
          result   = a - 1'b1;
          flag_src = result;
          zsp_upd  = 1'b1;
        end
        ROT_RLC: begin
          result           = {a[DATA_W-2:0], a[DATA_W-1]};
          flags_next.carry = a[DATA_W-1];
        end
        ROT_RRC: begin
          result           = {a[0], a[DATA_W-1:1]};
          flags_next.carry = a[0];
        end
        ROT_RAL: begin
          result           = {a[DATA_W-2:0], flags.carry};  // Through carry
          flags_next.carry = a[DATA_W-1];
        end
        ROT_RAR: begin
          result           = {flags.carry, a[DATA_W-1:1]};
          flags_next.carry = a[0];
        end
        default: result = a;
      endcase
    end else begin
      unique case (alu_ctrl.op)
        ALU_ADD: sum = {1'b0, a} + {1'b0, b};
        ALU_ADC: sum = {1'b0, a} + {1'b0, b} + {{DATA_W{1'b0}}, flags.carry};
        ALU_SUB, ALU_CMP: sum = {1'b0, a} - {1'b0, b};
        ALU_SBB: sum = {1'b0, a} - {1'b0, b} - {{DATA_W{1'b0}}, flags.carry};
        ALU_AND: sum = {1'b0, a & b};
        ALU_XOR: sum = {1'b0, a ^ b};
        ALU_OR:  sum = {1'b0, a | b};
      endcase
      result           = (alu_ctrl.op == ALU_CMP) ? a : sum[DATA_W-1:0];
      flag_src         = sum[DATA_W-1:0];  // Compare flags come from the difference
      flags_next.carry = sum[DATA_W];
      zsp_upd          = 1'b1;
    end
    if (zsp_upd) begin
      flags_next.zero   = (flag_src == '0);
      flags_next.sign   = flag_src[DATA_W-1];
      flags_next.parity = ~^flag_src;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (alu_ctrl.flag_en) begin
      flags <= flags_next;
    end
  end

endmodule

// ==== design/i8008_reg_file.sv ====
`timescale 1ns/1ps

module i8008_reg_file import i8008_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  rf_ctrl_t          rf_ctrl,
  input  logic [DATA_W-1:0] wdata,
  output logic [DATA_W-1:0] rdata,
  output logic [DATA_W-1:0] acc
);

  logic [DATA_W-1:0] regs [7];  // A, B, C, D, E, H, L

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 7; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_ctrl.we && rf_ctrl.sel != REG_M) begin
      regs[rf_ctrl.sel] <= wdata;
    end
  end

  // M has no storage here
  assign rdata = (rf_ctrl.sel == REG_M) ? '0 : regs[rf_ctrl.sel];
  assign acc   = regs[REG_A];

endmodule

// ==== design/i8008_decoder.sv ====
`timescale 1ns/1ps

module i8008_decoder import i8008_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [DATA_W-1:0] instr,
  input  logic              cond_true,
  input  logic              bus_done,
  output ctrl_t             ctrl,
  output logic              stopped
);

  state_t   state, next_state;
  cycle_t   cycle, next_cycle;
  reg_sel_t ddd, sss;
  logic     is_out;

  assign ddd     = reg_sel_t'(instr[5:3]);
  assign sss     = reg_sel_t'(instr[2:0]);
  assign is_out  = (instr[7:6] == 2'b01) && instr[0] && (instr[5:4] != 2'b00);
  assign stopped = (state == STOPPED);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= T1;
      cycle <= CYCLE1;
    end else begin
      state <= next_state;
      cycle <= next_cycle;
    end
  end

  always_comb begin
    ctrl       = '0;
    next_state = state;
    next_cycle = cycle;
    unique case (state)
      T1: begin
        ctrl.bus_start = 1'b1;
        ctrl.bus_kind  = (cycle == CYCLE2 && is_out) ? PORT_WRITE : MEM_READ;
        next_state     = T2;
      end
      T2: begin
        ctrl.pc_inc = !(cycle == CYCLE2 && is_out);  // Port write is not a PC fetch
        next_state  = WAIT;
      end
      WAIT: begin
        // Sits here while the memory holds off ack
        if (bus_done) begin
          ctrl.ir_ld = (cycle == CYCLE1);
          next_state = T3;
        end
      end
      T3: begin
        next_state = T1;
        next_cycle = CYCLE1;
        unique case (cycle)
          CYCLE1: begin
            casez (instr)
              HLT, HLT0: next_state = STOPPED;
              LRR: if (ddd != REG_M && sss != REG_M) next_state = T4;
              ALU_R: begin
                if (sss != REG_M) begin
                  ctrl.rf.sel = REG_A;  // Accumulator into temp A
                  ctrl.rf.re  = 1'b1;
                  ctrl.a_we   = 1'b1;
                  next_state  = T4;
                end
              end
              ALU_I: begin
                ctrl.rf.sel = REG_A;
                ctrl.rf.re  = 1'b1;
                ctrl.a_we   = 1'b1;
                next_cycle  = CYCLE2;
              end
              LRI: if (ddd != REG_M) next_cycle = CYCLE2;
              INR, DCR: if (ddd != REG_M) next_state = T4;
              ROT: next_state = T4;
              JMP, JCOND: next_cycle = CYCLE2;
              OUT: if (is_out) next_cycle = CYCLE2;
              default: ;  // Unsupported opcodes act as no-ops
            endcase
          end
          CYCLE2: begin
            casez (instr)
              LRI: begin
                ctrl.rd_re  = 1'b1;
                ctrl.rf.sel = ddd;
                ctrl.rf.we  = 1'b1;
              end
              ALU_I: begin
                ctrl.rd_re = 1'b1;
                ctrl.b_we  = 1'b1;
                next_state = T4;
                next_cycle = CYCLE2;
              end
              JMP, JCOND: begin
                ctrl.rd_re = 1'b1;
                ctrl.b_we  = 1'b1;  // Low address byte
                next_cycle = CYCLE3;
              end
              default: ;
            endcase
          end
          default: begin
            ctrl.rd_re = 1'b1;
            ctrl.a_we  = 1'b1;  // High address byte
            // JMP has bit 2 set, a failed condition goes back to fetch
            if (instr[2] || cond_true) begin
              next_state = T4;
              next_cycle = CYCLE3;
            end
          end
        endcase
      end
      T4: begin
        next_state = T5;
        unique case (cycle)
          CYCLE1: begin
            ctrl.rf.re = 1'b1;
            casez (instr)
              LRR, ALU_R: begin
                ctrl.rf.sel = sss;
                ctrl.b_we   = 1'b1;
              end
              INR, DCR: begin
                ctrl.rf.sel = ddd;
                ctrl.a_we   = 1'b1;
              end
              default: begin  // Rotates
                ctrl.rf.sel = REG_A;
                ctrl.a_we   = 1'b1;
              end
            endcase
          end
          CYCLE2: begin
            ctrl.alu.op      = alu_op_t'(instr[5:3]);  // Immediate ALU result
            ctrl.alu.flag_en = 1'b1;
            ctrl.alu.re      = 1'b1;
            ctrl.rf.sel      = REG_A;
            ctrl.rf.we       = 1'b1;
            next_state       = T1;
            next_cycle       = CYCLE1;
          end
          default: begin
            ctrl.a_re     = 1'b1;
            ctrl.pc_ld_hi = 1'b1;
          end
        endcase
      end
      T5: begin
        next_state = T1;
        next_cycle = CYCLE1;
        if (cycle == CYCLE3) begin
          ctrl.b_re     = 1'b1;
          ctrl.pc_ld_lo = 1'b1;
        end else begin
          casez (instr)
            LRR: begin
              ctrl.b_re   = 1'b1;
              ctrl.rf.sel = ddd;
              ctrl.rf.we  = 1'b1;
            end
            ALU_R: begin
              ctrl.alu.op      = alu_op_t'(instr[5:3]);
              ctrl.alu.flag_en = 1'b1;
              ctrl.alu.re      = 1'b1;
              ctrl.rf.sel      = REG_A;
              ctrl.rf.we       = 1'b1;
            end
            INR, DCR: begin
              ctrl.alu.arith   = 1'b1;
              ctrl.alu.rot     = instr[0] ? ROT_DEC : ROT_INC;
              ctrl.alu.flag_en = 1'b1;
              ctrl.alu.re      = 1'b1;
              ctrl.rf.sel      = ddd;
              ctrl.rf.we       = 1'b1;
            end
            ROT: begin
              ctrl.alu.arith   = 1'b1;
              ctrl.alu.rot     = rot_op_t'({1'b0, instr[4:3]} + 3'd2);  // RLC first
              ctrl.alu.flag_en = 1'b1;
              ctrl.alu.re      = 1'b1;
              ctrl.rf.sel      = REG_A;
              ctrl.rf.we       = 1'b1;
            end
            default: ;
          endcase
        end
      end
      STOPPED: next_state = STOPPED;  // Only reset leaves
      default: begin
        next_state = T1;
        next_cycle = CYCLE1;
      end
    endcase
  end

endmodule

// ==== design/i8008_bus_ctrl.sv ====
`timescale 1ns/1ps

module i8008_bus_ctrl import i8008_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  bus_cmd_t          cmd_in,
  output logic              bus_req,
  output bus_cmd_t          bus_cmd,
  input  logic              bus_ack,
  input  logic [DATA_W-1:0] bus_rdata,
  output logic [DATA_W-1:0] rdata,
  output logic              done
);

  typedef enum logic [1:0] {
    BC_IDLE,
    BC_REQ,     // Req high, waiting for ack
    BC_ACK_LO   // Req dropped, waiting for ack to fall
  } bc_state_t;

  bc_state_t state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= BC_IDLE;
    end else begin
      unique case (state)
        BC_IDLE:   if (start) state <= BC_REQ;
        BC_REQ:    if (bus_ack) state <= BC_ACK_LO;
        BC_ACK_LO: if (!bus_ack) state <= BC_IDLE;
        default:   state <= BC_IDLE;
      endcase
    end
  end

  // Command held for the whole transaction, read byte taken on first ack
  always_ff @(posedge clk) begin
    if (state == BC_IDLE && start) bus_cmd <= cmd_in;
    if (state == BC_REQ && bus_ack) rdata <= bus_rdata;
  end

  assign bus_req = (state == BC_REQ);
  assign done    = (state == BC_ACK_LO) && !bus_ack;

endmodule

// ==== design/i8008_datapath.sv ====
`timescale 1ns/1ps

module i8008_datapath import i8008_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  ctrl_t             ctrl,
  input  logic [DATA_W-1:0] rdata,
  output logic [DATA_W-1:0] instr,
  output logic              cond_true,
  output bus_cmd_t          cmd
);

  logic [ADDR_W-1:0] pc;
  logic [DATA_W-1:0] ir;
  logic [DATA_W-1:0] tmp_a;
  logic [DATA_W-1:0] tmp_b;
  logic [DATA_W-1:0] ibus;      // Internal data bus
  logic [DATA_W-1:0] rf_rdata;
  logic [DATA_W-1:0] acc;
  logic [DATA_W-1:0] alu_result;
  flags_t            flags;
  logic              flag_sel;

  i8008_reg_file i8008_reg_file_inst (
    .clk     (clk),
    .rst     (rst),
    .rf_ctrl (ctrl.rf),
    .wdata   (ibus),
    .rdata   (rf_rdata),
    .acc     (acc)
  );

  i8008_alu i8008_alu_inst (
    .clk      (clk),
    .rst      (rst),
    .a        (tmp_a),
    .b        (tmp_b),
    .alu_ctrl (ctrl.alu),
    .result   (alu_result),
    .flags    (flags)
  );

  always_comb begin
    if (ctrl.rf.re)       ibus = rf_rdata;
    else if (ctrl.alu.re) ibus = alu_result;
    else if (ctrl.a_re)   ibus = tmp_a;
    else if (ctrl.b_re)   ibus = tmp_b;
    else if (ctrl.rd_re)  ibus = rdata;
    else                  ibus = '0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (ctrl.pc_inc) begin
      pc <= pc + 1'b1;
    end else begin
      if (ctrl.pc_ld_lo) pc[7:0] <= ibus;
      if (ctrl.pc_ld_hi) pc[ADDR_W-1:8] <= ibus[ADDR_W-9:0];  // Upper six bits
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.ir_ld) ir <= rdata;
    if (ctrl.a_we) tmp_a <= ibus;
    if (ctrl.b_we) tmp_b <= ibus;
  end

  assign instr = ir;

  // Condition code in bits 4:3
  always_comb begin
    unique case (ir[4:3])
      2'b00:   flag_sel = flags.carry;
      2'b01:   flag_sel = flags.zero;
      2'b10:   flag_sel = flags.sign;
      default: flag_sel = flags.parity;
    endcase
  end

  assign cond_true = ir[5] ? flag_sel : !flag_sel;  // JTc on set, JFc on clear

  assign cmd.kind  = ctrl.bus_kind;
  assign cmd.addr  = (ctrl.bus_kind == PORT_WRITE) ? {{(ADDR_W-5){1'b0}}, ir[5:1]} : pc;
  assign cmd.wdata = acc;

endmodule

// ==== design/i8008_core.sv ====
`timescale 1ns/1ps

module i8008_core import i8008_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  output logic              bus_req,
  output bus_cmd_t          bus_cmd,
  input  logic              bus_ack,
  input  logic [DATA_W-1:0] bus_rdata,
  output logic              halted
);

  ctrl_t             ctrl;
  logic [DATA_W-1:0] instr;
  logic [DATA_W-1:0] rdata;     // Byte captured by the bus controller
  logic              cond_true;
  logic              bus_done;
  bus_cmd_t          dp_cmd;

  i8008_decoder i8008_decoder_inst (
    .clk       (clk),
    .rst       (rst),
    .instr     (instr),
    .cond_true (cond_true),
    .bus_done  (bus_done),
    .ctrl      (ctrl),
    .stopped   (halted)
  );

  i8008_bus_ctrl i8008_bus_ctrl_inst (
    .clk       (clk),
    .rst       (rst),
    .start     (ctrl.bus_start),
    .cmd_in    (dp_cmd),
    .bus_req   (bus_req),
    .bus_cmd   (bus_cmd),
    .bus_ack   (bus_ack),
    .bus_rdata (bus_rdata),
    .rdata     (rdata),
    .done      (bus_done)
  );

  i8008_datapath i8008_datapath_inst (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .rdata     (rdata),
    .instr     (instr),
    .cond_true (cond_true),
    .cmd       (dp_cmd)
  );

endmodule

// ==== tests/tb_programs.svh ====
// Program image, written by the builders below
logic [7:0]  prog [int];
int          asm_pc;
logic [13:0] exp_reads [$];   // Every address the core should read, in order
logic [15:0] exp_writes [$];  // {port, data} per port write
logic [13:0] halt_addr;

// Reference machine state, updated as each instruction is emitted
logic [7:0] m_reg [8];
logic       m_c;
logic       m_z;
logic       m_s;
logic       m_p;

task automatic start_program();
  prog.delete();
  exp_reads.delete();
  exp_writes.delete();
  asm_pc = 0;
  for (int r = 0; r < 8; r++) begin
    m_reg[r] = 8'h00;
  end
  m_c = 1'b0;
  m_z = 1'b0;
  m_s = 1'b0;
  m_p = 1'b0;
endtask

task automatic emit_byte(input logic [7:0] b, input bit fetched);
  prog[asm_pc] = b;
  if (fetched) exp_reads.push_back(asm_pc[13:0]);
  asm_pc++;
endtask

task automatic set_zsp(input logic [7:0] v);
  m_z = (v == 8'h00);
  m_s = v[7];
  m_p = ~^v;  // Even number of ones
endtask

task automatic load_imm(input int d, input logic [7:0] v);
  emit_byte({2'b00, d[2:0], 3'b110}, 1'b1);
  emit_byte(v, 1'b1);
  m_reg[d] = v;
endtask

task automatic move_reg(input int d, input int s);
  emit_byte({2'b11, d[2:0], s[2:0]}, 1'b1);
  m_reg[d] = m_reg[s];
endtask

// Register form uses source s, immediate form uses v
task automatic alu_instr(input int p, input bit imm, input int s, input logic [7:0] v);
  int         a;
  int         b;
  int         wide;
  logic [7:0] res;
  a = int'(m_reg[0]);
  b = imm ? int'(v) : int'(m_reg[s]);
  if (imm) begin
    emit_byte({2'b00, p[2:0], 3'b100}, 1'b1);
    emit_byte(v, 1'b1);
  end else begin
    emit_byte({2'b10, p[2:0], s[2:0]}, 1'b1);
  end
  case (p)
    0: wide = a + b;
    1: wide = a + b + int'(m_c);
    2: wide = a - b;
    3: wide = a - b - int'(m_c);
    4: wide = a & b;
    5: wide = a ^ b;
    6: wide = a | b;
    default: wide = a - b;  // Compare
  endcase
  res = wide[7:0];
  m_c = (wide < 0) || (wide > 255);
  set_zsp(res);
  if (p != 7) m_reg[0] = res;
endtask

task automatic step_reg(input int d, input bit dec);
  emit_byte({2'b00, d[2:0], 2'b00, dec}, 1'b1);
  m_reg[d] = dec ? m_reg[d] - 8'h01 : m_reg[d] + 8'h01;
  set_zsp(m_reg[d]);  // Carry untouched
endtask

task automatic rotate_acc(input int r);
  logic [7:0] a;
  a = m_reg[0];
  emit_byte({3'b000, r[1:0], 3'b010}, 1'b1);
  case (r)
    0: begin
      m_reg[0] = {a[6:0], a[7]};
      m_c      = a[7];
    end
    1: begin
      m_reg[0] = {a[0], a[7:1]};
      m_c      = a[0];
    end
    2: begin
      m_reg[0] = {a[6:0], m_c};
      m_c      = a[7];
    end
    default: begin
      m_reg[0] = {m_c, a[7:1]};
      m_c      = a[0];
    end
  endcase
endtask

task automatic out_acc(input int port);
  emit_byte({2'b01, port[4:0], 1'b1}, 1'b1);
  exp_writes.push_back({3'b000, port[4:0], m_reg[0]});
endtask

// Jump over one OUT 30, which only shows up when the jump is not taken
task automatic jump_over_marker(input bit cond, input bit t, input int c);
  int   target;
  logic f;
  logic taken;
  case (c)
    0: f = m_c;
    1: f = m_z;
    2: f = m_s;
    default: f = m_p;
  endcase
  taken  = !cond || (t ? f : !f);
  target = asm_pc + 4;
  emit_byte(cond ? {2'b01, t, c[1:0], 3'b000} : 8'h44, 1'b1);
  emit_byte(target[7:0], 1'b1);
  emit_byte({2'b00, target[13:8]}, 1'b1);
  emit_byte(8'h7d, !taken);
  if (!taken) exp_writes.push_back({8'd30, m_reg[0]});
endtask

task automatic jump_far(input int target);
  emit_byte(8'h44, 1'b1);
  emit_byte(target[7:0], 1'b1);
  emit_byte({2'b00, target[13:8]}, 1'b1);
  asm_pc = target;
endtask

task automatic halt_instr();
  halt_addr = asm_pc[13:0];
  emit_byte(8'hff, 1'b1);
endtask

// ==== tests/tb_i8008.sv ====
`timescale 1ns/1ps

module tb_i8008 import i8008_pkg::*; ();

  localparam int MEM_SIZE     = 16384;
  localparam int RUN_LIMIT    = 20000;
  localparam int QUIET_WINDOW = 30;

  logic              clk;
  logic              rst;
  logic              bus_req;
  bus_cmd_t          bus_cmd;
  logic              bus_ack;
  logic [DATA_W-1:0] bus_rdata;
  logic              halted;

  logic [7:0]  mem [MEM_SIZE];
  logic [13:0] read_log [$];
  logic [15:0] write_log [$];
  int          seed = 32'h8979_5e59;
  int          wait_left;
  int          hold_left;
  int          err_count;
  int          tests_passed;
  int          tests_failed;

  `include "tb_programs.svh"

  i8008_core i8008_core_inst (
    .clk       (clk),
    .rst       (rst),
    .bus_req   (bus_req),
    .bus_cmd   (bus_cmd),
    .bus_ack   (bus_ack),
    .bus_rdata (bus_rdata),
    .halted    (halted)
  );

  always #4 clk = ~clk;

  // Memory and port responder with random ack delay and ack hold
  always @(negedge clk) begin
    if (rst) begin
      bus_ack   = 1'b0;
      wait_left = -1;
      hold_left = -1;
    end else if (bus_ack) begin
      if (!bus_req) begin
        // Ack lingers up to 5 cycles after req drops
        if (hold_left < 0) hold_left = $unsigned($random(seed)) % 6;
        if (hold_left == 0) begin
          bus_ack   = 1'b0;
          hold_left = -1;
        end else begin
          hold_left--;
        end
      end
    end else if (bus_req) begin
      if (wait_left < 0) wait_left = $unsigned($random(seed)) % 6;
      if (wait_left == 0) begin
        if (bus_cmd.kind == MEM_READ) begin
          bus_rdata = mem[bus_cmd.addr];
          read_log.push_back(bus_cmd.addr);
        end else begin
          write_log.push_back({bus_cmd.addr[7:0], bus_cmd.wdata});
        end
        bus_ack   = 1'b1;
        wait_left = -1;
      end else begin
        wait_left--;
      end
    end
  end

  cmd_stable: assert property (@(posedge clk) disable iff (rst)
    (bus_req && $past(bus_req)) |-> (bus_cmd == $past(bus_cmd)))
    else begin
      err_count++;
      $display("error: %0t bus_cmd changed while bus_req was high", $time);
    end

  req_after_ack_low: assert property (@(posedge clk) disable iff (rst)
    $rose(bus_req) |-> !$past(bus_ack))
    else begin
      err_count++;
      $display("error: %0t bus_req rose while bus_ack was high", $time);
    end

  task automatic expect_eq(input int got, input int exp, input string what);
    assert (got == exp)
      else begin
        err_count++;
        $display("error: %0t %s: got %0h, expected %0h", $time, what, got, exp);
      end
  endtask

  task automatic report_failure(input string msg);
    err_count++;
    $display("%s", msg);
  endtask

  task automatic run_program(input string name);
    int errs_before;
    int cycles;
    int n;
    errs_before = err_count;
    for (int a = 0; a < MEM_SIZE; a++) begin
      mem[a] = a[7:0] ^ {2'b00, a[13:8]};
    end
    foreach (prog[a]) mem[a] = prog[a];
    read_log.delete();
    write_log.delete();
    @(negedge clk);
    rst = 1'b1;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    expect_eq(int'(bus_req), 0, "bus_req after reset");
    expect_eq(int'(halted), 0, "halted after reset");
    cycles = 0;
    while (!bus_req && cycles < 2) begin
      @(negedge clk);
      cycles++;
    end
    if (!bus_req) begin
      report_failure("No bus request within 2 cycles after reset");
    end else begin
      expect_eq(int'(bus_cmd.kind), int'(MEM_READ), "first request kind");
      expect_eq(int'(bus_cmd.addr), 0, "first request address");
    end
    cycles = 0;
    while (!halted && cycles < RUN_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      report_failure($sformatf("Core in %s did not halt before the timeout", name));
    end else begin
      // Halted core must stay quiet
      cycles = 0;
      while (cycles < QUIET_WINDOW) begin
        @(negedge clk);
        expect_eq(int'(bus_req), 0, "bus_req after halt");
        expect_eq(int'(halted), 1, "halted held");
        cycles++;
      end
    end
    if (read_log.size() != exp_reads.size())
      report_failure($sformatf("Read count %0d differs from expected %0d",
                               read_log.size(), exp_reads.size()));
    n = (read_log.size() < exp_reads.size()) ? read_log.size() : exp_reads.size();
    for (int i = 0; i < n; i++) begin
      expect_eq(int'(read_log[i]), int'(exp_reads[i]), $sformatf("read address %0d", i));
    end
    if (write_log.size() != exp_writes.size())
      report_failure($sformatf("Port write count %0d differs from expected %0d",
                               write_log.size(), exp_writes.size()));
    n = (write_log.size() < exp_writes.size()) ? write_log.size() : exp_writes.size();
    for (int i = 0; i < n; i++) begin
      expect_eq(int'(write_log[i]), int'(exp_writes[i]), $sformatf("port write %0d", i));
    end
    if (read_log.size() > 0)
      expect_eq(int'(read_log[read_log.size()-1]), int'(halt_addr), "halt address");
    if (err_count == errs_before) begin
      tests_passed++;
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: FAILED", name);
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    bus_ack      = 1'b0;
    bus_rdata    = '0;
    err_count    = 0;
    tests_passed = 0;
    tests_failed = 0;

    // Loads into every register and moves followed by OUT
    start_program();
    for (int d = 1; d < 7; d++) load_imm(d, 8'($random(seed)));
    load_imm(0, 8'($random(seed)));
    out_acc(8);
    for (int s = 1; s < 7; s++) begin
      move_reg(0, s);
      out_acc(8 + s);
    end
    move_reg(1, 2);
    move_reg(0, 1);
    out_acc(20);
    halt_instr();
    run_program("register loads and moves");

    // Every ALU op in register and immediate form with the carry chained through
    start_program();
    for (int p = 0; p < 8; p++) begin
      for (int f = 0; f < 2; f++) begin
        load_imm(0, 8'($random(seed)));
        if (f == 0) begin
          load_imm(2, 8'($random(seed)));
          alu_instr(p, 1'b0, 2, 8'h00);
        end else begin
          alu_instr(p, 1'b1, 0, 8'($random(seed)));
        end
        out_acc(8 + p * 2 + f);
      end
    end
    halt_instr();
    run_program("alu operations");

    start_program();
    for (int d = 1; d < 7; d++) begin
      load_imm(d, 8'($random(seed)));
      step_reg(d, d[0]);
      move_reg(0, d);
      out_acc(8 + d);
    end
    for (int r = 0; r < 8; r++) begin
      load_imm(0, 8'($random(seed)));
      rotate_acc(r % 4);
      out_acc(16 + r);
    end
    load_imm(0, 8'h80);
    rotate_acc(0);             // Carry set
    load_imm(1, 8'hff);
    step_reg(1, 1'b0);         // Zero result with carry kept
    jump_over_marker(1'b1, 1'b0, 0);
    jump_over_marker(1'b1, 1'b1, 1);
    step_reg(1, 1'b1);
    jump_over_marker(1'b1, 1'b1, 2);
    jump_over_marker(1'b1, 1'b1, 0);
    jump_over_marker(1'b1, 1'b1, 3);
    halt_instr();
    run_program("increment, decrement and rotates");

    // Both flag states so each jump is taken once and skipped once
    start_program();
    load_imm(0, 8'h00);
    alu_instr(6, 1'b1, 0, 8'h00);
    jump_over_marker(1'b0, 1'b0, 0);
    for (int c = 0; c < 4; c++) begin
      jump_over_marker(1'b1, 1'b0, c);
      jump_over_marker(1'b1, 1'b1, c);
    end
    load_imm(0, 8'hf0);
    alu_instr(0, 1'b1, 0, 8'h93);
    for (int c = 0; c < 4; c++) begin
      jump_over_marker(1'b1, 1'b0, c);
      jump_over_marker(1'b1, 1'b1, c);
    end
    jump_far(14'h2345);
    load_imm(0, 8'h3c);
    out_acc(9);
    halt_instr();
    run_program("jumps");

    $display("Tests passed: %0d, failed: %0d, check errors: %0d",
             tests_passed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+tests
design/i8008_pkg.sv
design/i8008_alu.sv
design/i8008_reg_file.sv
design/i8008_decoder.sv
design/i8008_bus_ctrl.sv
design/i8008_datapath.sv
design/i8008_core.sv
tests/tb_i8008.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_i8008 -o sim_tb
output=$(./obj_dir/sim_tb)
echo "$output"

if echo "$output" | grep -q 'All tests passed!'; then
  exit 0
fi
exit 1
